//--- all.f
+incdir+include
design/fp_mul_pkg.sv
design/fp_unpack_stage.sv
design/fp_product_stage.sv
design/fp_round_stage.sv
design/fp_mul_top.sv
testbench/fp_mul_chk.sv
testbench/fp_mul_tb.sv

//--- Bender.yml
package:
  name: fp_mul

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/fp_mul_pkg.sv
      - design/fp_unpack_stage.sv
      - design/fp_product_stage.sv
      - design/fp_round_stage.sv
      - design/fp_mul_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/fp_mul_chk.sv
      - testbench/fp_mul_tb.sv

//--- testbench/fp_mul_vectors.txt
# Columns: test name, operand a, operand b, expected result (FP32 words in hex)
# Subnormal operands count as zero, underflow flushes to a signed zero
exact_1p5_x_2 3FC00000 40000000 40400000
exact_neg_1p5_x_2 BFC00000 40000000 C0400000
exact_1p5_x_1p5 3FC00000 3FC00000 40100000
exact_3_x_3 40400000 40400000 41100000
one_x_one 3F800000 3F800000 3F800000
round_down_sticky 3F800001 3FA00000 3FA00001
round_up_sticky 3F800001 3FE00000 3FE00002
tie_odd_rounds_up 3F800001 3FC00000 3FC00002
tie_even_stays 3F800003 3FC00000 3FC00004
shift_with_sticky 3FFFFFFF 3FFFFFFF 407FFFFE
round_carry_into_exp 3FE12000 3F918E00 40000000
max_finite_x_one 7F7FFFFF 3F800000 7F7FFFFF
overflow_pos 7F000000 40000000 7F800000
overflow_neg FF000000 40000000 FF800000
overflow_by_round_carry 7F612000 3F918E00 7F800000
min_normal_x_one 00800000 3F800000 00800000
underflow_flush_pos 00800000 3F000000 00000000
underflow_flush_neg 80800000 3F000000 80000000
tiny_x_tiny 00800000 00800000 00000000
nan_a 7FA00000 3F800000 7FC00000
nan_b 40000000 FFC00000 7FC00000
nan_x_zero 7FC00000 00000000 7FC00000
inf_x_zero 7F800000 00000000 7FC00000
neg_zero_x_neg_inf 80000000 FF800000 7FC00000
inf_x_neg_two 7F800000 C0000000 FF800000
neg_inf_x_neg_one FF800000 BF800000 7F800000
inf_x_neg_inf 7F800000 FF800000 FF800000
neg_zero_x_three 80000000 40400000 80000000
zero_x_three 00000000 40400000 00000000
denorm_x_two 00000001 40000000 00000000
neg_denorm_x_one 807FFFFF 3F800000 80000000
denorm_x_inf 00400000 7F800000 7FC00000

//--- testbench/fp_mul_tb.sv
`default_nettype none
`timescale 1ns/100ps

module fp_mul_tb;

    localparam int WAIT_LIMIT = 20;    // Cycles allowed while a result is outstanding
    localparam int LATENCY    = 3;

    // One line of the vector file
    typedef struct packed {
        fp_mul_pkg::fp32_u a;
        fp_mul_pkg::fp32_u b;
        fp_mul_pkg::fp32_u expected;
    } vector_t;

    // One pair in flight
    typedef struct packed {
        fp_mul_pkg::fp32_u expected;
        logic [31:0]       sample_edge;    // Rising edge that takes the pair in
    } pending_t;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              in_valid;
    fp_mul_pkg::fp32_u a;
    fp_mul_pkg::fp32_u b;
    logic              out_valid;
    fp_mul_pkg::fp32_u result;

    logic [31:0] edge_count   = '0;
    logic [31:0] lfsr_state   = 32'h5413_5677;
    int          stall_cycles = 0;
    vector_t     vec_q[$];
    string       vec_name_q[$];
    pending_t    pend_q[$];
    string       pend_name_q[$];

    fp_mul_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) edge_count <= edge_count + 1;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_gap(output int gap);
        logic [1:0] bits;
        bits[0]    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        bits[1]    = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        gap        = int'(bits);
    endtask

    task automatic abort_run(input string why);
        $display("Testbench failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_result(input string name, input fp_mul_pkg::fp32_u expected,
                                input fp_mul_pkg::fp32_u actual);
        if (actual.raw !== expected.raw) begin
            $display("FAIL %s: expected %08h, actual %08h", name, expected.raw, actual.raw);
            $display("Testbench failed");
            $fatal(1, "Result mismatch");
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAIL %s latency: expected %0d, actual %0d", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Latency mismatch");
        end
    endtask

    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        string   name;
        vector_t v;
        fd = $fopen("testbench/fp_mul_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open testbench/fp_mul_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin    // Skip comment lines
                n = $sscanf(line, "%s %h %h %h", name, v.a.raw, v.b.raw, v.expected.raw);
                if (n == 4) begin
                    vec_q.push_back(v);
                    vec_name_q.push_back(name);
                end
            end
        end
        $fclose(fd);
        if (vec_q.size() == 0) begin
            abort_run("The vector file held no usable lines");
        end
    endtask

    initial begin : stimulus
        int       gap;
        int       drain;
        pending_t p;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        load_vectors();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        foreach (vec_q[i]) begin
            random_gap(gap);    // 0 gives back-to-back issue
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            a        <= vec_q[i].a;
            b        <= vec_q[i].b;
            // edge_count has not yet counted this edge
            p.expected    = vec_q[i].expected;
            p.sample_edge = edge_count + 2;
            pend_q.push_back(p);
            pend_name_q.push_back(vec_name_q[i]);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        drain = 0;
        while (pend_q.size() != 0) begin
            @(posedge clk);
            drain++;
            if (drain > WAIT_LIMIT) begin
                abort_run("Timed out waiting for the pipeline to drain");
            end
        end
        repeat (4) @(negedge clk);    // Idle window, no stray out_valid
        if (i_dut.i_chk.fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run("A handshake assertion failed");
        end
    end

    // Outputs are sampled mid-cycle where they are stable
    always @(negedge clk) begin : collect
        pending_t p;
        string    name;
        if (rst_n && out_valid) begin
            if (pend_q.size() == 0) begin
                abort_run("out_valid was high with no operand pair outstanding");
            end else begin
                p    = pend_q.pop_front();
                name = pend_name_q.pop_front();
                check_result(name, p.expected, result);
                check_latency(name, LATENCY, int'(edge_count + 1 - p.sample_edge));
            end
            stall_cycles = 0;
        end else if (pend_q.size() != 0) begin
            stall_cycles++;
            if (stall_cycles > WAIT_LIMIT) begin
                abort_run("Timed out waiting for out_valid");
            end
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_chk.fail_count != 0) begin
            abort_run("A handshake assertion failed");
        end
    end

endmodule

`default_nettype wire

//--- testbench/fp_mul_chk.sv
`default_nettype none
`timescale 1ns/100ps

module fp_mul_chk (
    input logic              clk,
    input logic              rst_n,
    input logic              in_valid,
    input logic              out_valid,
    input fp_mul_pkg::fp32_u result
);

    int fail_count = 0;    // Failed assertions so far

    // Checked mid-cycle while reset is held
    quiet_in_reset: assert property (@(negedge clk) !rst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high while rst_n is low");
        end

    three_cycle_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 3))
        else begin
            fail_count++;
            $error("out_valid does not follow in_valid by three cycles");
        end

    hold_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> $stable(result))
        else begin
            fail_count++;
            $error("result changed while out_valid was low");
        end

endmodule

bind fp_mul_top fp_mul_chk i_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result)
);

`default_nettype wire

//--- design/fp_mul_top.sv
`default_nettype none
`timescale 1ns/100ps

module fp_mul_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  fp_mul_pkg::fp32_u  a,
    input  fp_mul_pkg::fp32_u  b,
    output logic               out_valid,
    output fp_mul_pkg::fp32_u  result
);

    fp_mul_pkg::s1_t s1;    // Decoded operands and classes
    fp_mul_pkg::s2_t s2;    // Product, exponent and special word

    fp_unpack_stage u_unpack (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .s1       (s1)
    );

    fp_product_stage u_product (
        .clk   (clk),
        .rst_n (rst_n),
        .s1    (s1),
        .s2    (s2)
    );

    // Three cycles from in_valid to out_valid
    fp_round_stage u_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .s2        (s2),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- design/fp_round_stage.sv
`default_nettype none
`timescale 1ns/100ps

`include "fp_mul_cfg.svh"

module fp_round_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  fp_mul_pkg::s2_t    s2,
    output logic               out_valid,
    output fp_mul_pkg::fp32_u  result
);

    localparam int PW = 2*`FP_MAN_BITS + 2;    // Product width, 48
    localparam int EW = `FP_EXP_BITS + 2;      // Working exponent width, 10

    logic                  shift;
    logic [PW-1:0]         prod_n;
    logic signed [EW-1:0]  exp_n;
    logic [`FP_MAN_BITS-1:0] frac_t;
    logic                  guard;
    logic                  sticky;
    logic                  round_up;
    logic [`FP_MAN_BITS:0] frac_r;
    logic signed [EW-1:0]  exp_r;
    logic                  overflow;
    logic                  underflow;
    fp_mul_pkg::fp32_u     word;

    // Leading one sits at bit 47 or bit 46 for normal operands
    assign shift  = s2.prod[PW-1];
    assign prod_n = shift ? (s2.prod >> 1) : s2.prod;
    assign exp_n  = $signed(s2.exp) + $signed(EW'(shift));

    // Hidden one at bit 46
    assign frac_t = prod_n[PW-3:PW-2-`FP_MAN_BITS];
    assign guard  = prod_n[PW-3-`FP_MAN_BITS];

    // Bit shifted out by the normalise step still counts toward sticky
    assign sticky = (|prod_n[PW-4-`FP_MAN_BITS:0]) || (shift && s2.prod[0]);

    // Nearest, ties to even
    assign round_up = guard && (sticky || frac_t[0]);
    assign frac_r   = {1'b0, frac_t} + (`FP_MAN_BITS+1)'(round_up);

    // Carry out of the fraction leaves zero fraction bits behind
    assign exp_r = $signed(exp_n) + $signed(EW'(frac_r[`FP_MAN_BITS]));

    assign overflow  = (exp_r >= $signed(EW'(`FP_EXP_MAX)));
    assign underflow = (exp_r < $signed(EW'(1)));

    always_comb begin
        word = '0;
        if (s2.special) begin
            word = s2.special_word;
        end else if (overflow) begin
            word.fields.sign = s2.sign;    // Signed infinity
            word.fields.exp  = `FP_EXP_BITS'(`FP_EXP_MAX);
        end else if (underflow) begin
            word.fields.sign = s2.sign;    // Flush to signed zero
        end else begin
            word.fields.sign = s2.sign;
            word.fields.exp  = exp_r[`FP_EXP_BITS-1:0];
            word.fields.frac = frac_r[`FP_MAN_BITS-1:0];
        end
    end

    // Result holds its last value between valid cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= s2.valid;
            if (s2.valid) begin
                result <= word;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/fp_product_stage.sv
`default_nettype none
`timescale 1ns/100ps

`include "fp_mul_cfg.svh"

module fp_product_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  fp_mul_pkg::s1_t  s1,
    output fp_mul_pkg::s2_t  s2
);

    logic                            sign;
    logic signed [`FP_EXP_BITS+1:0]  exp_sum;
    logic [`FP_MAN_BITS:0]           a_sig;
    logic [`FP_MAN_BITS:0]           b_sig;
    logic [2*`FP_MAN_BITS+1:0]       prod;
    logic                            res_nan;
    logic                            res_inf;
    logic                            res_zero;
    fp_mul_pkg::fp32_u               special_word;

    assign sign  = s1.a_sign ^ s1.b_sign;
    assign a_sig = {1'b1, s1.a_frac};    // Restore hidden one
    assign b_sig = {1'b1, s1.b_frac};
    assign prod  = a_sig * b_sig;

    // Wraps modulo 2^10, read as two's complement downstream
    assign exp_sum = (`FP_EXP_BITS+2)'(s1.a_exp) + (`FP_EXP_BITS+2)'(s1.b_exp)
                   - (`FP_EXP_BITS+2)'(`FP_BIAS);

    assign res_nan  = s1.a_class.is_nan || s1.b_class.is_nan
                   || (s1.a_class.is_inf && s1.b_class.is_zero)
                   || (s1.b_class.is_inf && s1.a_class.is_zero);
    assign res_inf  = s1.a_class.is_inf || s1.b_class.is_inf;
    assign res_zero = s1.a_class.is_zero || s1.b_class.is_zero;

    // NaN first, then inf, then zero
    always_comb begin
        special_word = '0;
        if (res_nan) begin
            special_word.raw = `FP_QNAN;
        end else if (res_inf) begin
            special_word.fields.sign = sign;
            special_word.fields.exp  = `FP_EXP_BITS'(`FP_EXP_MAX);
        end else if (res_zero) begin
            special_word.fields.sign = sign;    // Signed zero
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2 <= '0;
        end else begin
            s2.valid <= s1.valid;
            if (s1.valid) begin
                s2.sign         <= sign;
                s2.exp          <= exp_sum;
                s2.prod         <= prod;
                s2.special      <= res_nan || res_inf || res_zero;
                s2.special_word <= special_word;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/fp_unpack_stage.sv
`default_nettype none
`timescale 1ns/100ps

`include "fp_mul_cfg.svh"

module fp_unpack_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  fp_mul_pkg::fp32_u   a,
    input  fp_mul_pkg::fp32_u   b,
    output fp_mul_pkg::s1_t     s1
);

    fp_mul_pkg::fp_class_t a_class;
    fp_mul_pkg::fp_class_t b_class;

    // Operand class from the field view of the word
    function automatic fp_mul_pkg::fp_class_t classify(input fp_mul_pkg::fp32_u w);
        fp_mul_pkg::fp_class_t c;
        logic                  exp_max;
        logic                  frac_nz;
        exp_max   = (w.fields.exp == `FP_EXP_MAX);
        frac_nz   = (w.fields.frac != '0);
        c.is_zero = (w.fields.exp == '0);    // Denormals are zero, fraction ignored
        c.is_inf  = exp_max && !frac_nz;
        c.is_nan  = exp_max && frac_nz;
        return c;
    endfunction

    assign a_class = classify(a);
    assign b_class = classify(b);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1 <= '0;
        end else begin
            s1.valid <= in_valid;
            if (in_valid) begin
                s1.a_sign  <= a.fields.sign;
                s1.b_sign  <= b.fields.sign;
                s1.a_exp   <= a.fields.exp;
                s1.b_exp   <= b.fields.exp;
                s1.a_frac  <= a.fields.frac;
                s1.b_frac  <= b.fields.frac;
                s1.a_class <= a_class;
                s1.b_class <= b_class;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/fp_mul_pkg.sv
`default_nettype none

`include "fp_mul_cfg.svh"

package fp_mul_pkg;

    // Field view of one FP32 word
    typedef struct packed {
        logic                    sign;
        logic [`FP_EXP_BITS-1:0] exp;
        logic [`FP_MAN_BITS-1:0] frac;    // Stored fraction, hidden one not included
    } fp32_fields_t;

    // Bus word at the ports, fields inside the stages
    typedef union packed {
        logic [`FP_WORD_BITS-1:0] raw;
        fp32_fields_t             fields;
    } fp32_u;

    typedef struct packed {
        logic is_zero;    // Zero or subnormal
        logic is_inf;
        logic is_nan;
    } fp_class_t;

    // Unpack stage to product stage
    typedef struct packed {
        logic                    valid;
        logic                    a_sign;
        logic                    b_sign;
        logic [`FP_EXP_BITS-1:0] a_exp;
        logic [`FP_EXP_BITS-1:0] b_exp;
        logic [`FP_MAN_BITS-1:0] a_frac;
        logic [`FP_MAN_BITS-1:0] b_frac;
        fp_class_t               a_class;
        fp_class_t               b_class;
    } s1_t;

    // Product stage to round stage
    typedef struct packed {
        logic                          valid;
        logic                          sign;
        logic signed [`FP_EXP_BITS+1:0] exp;    // Biased, before normalisation
        logic [2*`FP_MAN_BITS+1:0]     prod;    // 24 x 24 significand product
        logic                          special;
        fp32_u                         special_word;
    } s2_t;

endpackage

`default_nettype wire

//--- include/fp_mul_cfg.svh
`ifndef FP_MUL_CFG_SVH
`define FP_MUL_CFG_SVH

// FP32 word layout
`define FP_EXP_BITS 8
`define FP_MAN_BITS 23
`define FP_WORD_BITS 32

// Exponent coding
`define FP_BIAS 127
`define FP_EXP_MAX 255    // All-ones exponent, inf or NaN

// Default quiet NaN, sign clear and fraction MSB set
`define FP_QNAN 32'h7FC0_0000

`endif
